//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_soc_lite
FLIST     ?= soc_lite.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

//--- boot_rom.sv
// boot rom
// constant table of boot words, read data registered on req

`timescale 1ns/100ps
`default_nettype none

module boot_rom (
  input  wire logic clk_i,
  mem_bus_if.slave  bus_i
);
  import soc_lite_pkg::*;

  data_t rdata_q;

  // word index from the byte offset
  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      rdata_q <= RomTable[bus_i.addr[5:2]];
    end
  end

  assign bus_i.rdata = rdata_q;

  // the decoder turns rom writes into errors before they get here
  a_no_rom_write: assert property (@(posedge clk_i)
    bus_i.req |-> !bus_i.we);

endmodule

`default_nettype wire

//--- clint_regs.sv
// clint register block
// holds mtimecmp and msip, decodes writes and reads for all clint
// registers and hands mtime writes to the timer as a load

`timescale 1ns/100ps
`default_nettype none

module clint_regs (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire soc_lite_pkg::mtime_t mtime_i,
  output soc_lite_pkg::mtime_t      mtimecmp_o,
  output logic                      msip_o,
  output logic                      mtime_we_o,
  output soc_lite_pkg::mtime_t      mtime_wdata_o,
  mem_bus_if.slave                  bus_i
);
  import soc_lite_pkg::*;

  data_t mtimecmp_lo_q;
  data_t mtimecmp_hi_q;
  logic  msip_q;
  logic  wr;
  data_t rdata_d;
  data_t rdata_q;

  assign wr = bus_i.req && bus_i.we;

  // ----------------------------------------
  // register writes
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtimecmp_lo_q <= '1;
      mtimecmp_hi_q <= '1;
      msip_q        <= 1'b0;
    end else if (wr) begin
      case (bus_i.addr)
        ClintMsipOff:       msip_q        <= bus_i.wdata[0];
        ClintMtimecmpLoOff: mtimecmp_lo_q <= bus_i.wdata;
        ClintMtimecmpHiOff: mtimecmp_hi_q <= bus_i.wdata;
        default: ;
      endcase
    end
  end

  // mtime write, other half kept from the running count
  always_comb begin
    mtime_we_o    = 1'b0;
    mtime_wdata_o = mtime_i;
    if (wr && (bus_i.addr == ClintMtimeLoOff)) begin
      mtime_we_o          = 1'b1;
      mtime_wdata_o[31:0] = bus_i.wdata;
    end else if (wr && (bus_i.addr == ClintMtimeHiOff)) begin
      mtime_we_o           = 1'b1;
      mtime_wdata_o[63:32] = bus_i.wdata;
    end
  end

  // ----------------------------------------
  // register reads
  // ----------------------------------------
  always_comb begin
    case (bus_i.addr)
      ClintMsipOff:       rdata_d = {31'b0, msip_q};
      ClintMtimecmpLoOff: rdata_d = mtimecmp_lo_q;
      ClintMtimecmpHiOff: rdata_d = mtimecmp_hi_q;
      ClintMtimeLoOff:    rdata_d = mtime_i[31:0];
      ClintMtimeHiOff:    rdata_d = mtime_i[63:32];
      default:            rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus_i.rdata = rdata_q;
  assign mtimecmp_o  = {mtimecmp_hi_q, mtimecmp_lo_q};
  assign msip_o      = msip_q;

  a_addr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_i.req |-> !$isunknown(bus_i.addr));

endmodule

`default_nettype wire

//--- clint_timer.sv
// clint timer
// synchronizes the rtc input, counts mtime on its rising edges
// and raises the timer interrupt once mtime reaches mtimecmp

`timescale 1ns/100ps
`default_nettype none

module clint_timer (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 rtc_i,
  input  wire soc_lite_pkg::mtime_t mtimecmp_i,
  input  wire logic                 mtime_we_i,
  input  wire soc_lite_pkg::mtime_t mtime_wdata_i,
  output soc_lite_pkg::mtime_t      mtime_o,
  output logic                      timer_irq_o
);
  import soc_lite_pkg::*;

  logic   rtc_s1_q;
  logic   rtc_s2_q;
  logic   rtc_prev_q;
  logic   tick;
  mtime_t mtime_q;
  logic   irq_q;

  // ----------------------------------------
  // rtc synchronizer and edge detect
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_s1_q   <= 1'b0;
      rtc_s2_q   <= 1'b0;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_s1_q   <= rtc_i;
      rtc_s2_q   <= rtc_s1_q;
      rtc_prev_q <= rtc_s2_q;
    end
  end

  assign tick = rtc_s2_q && !rtc_prev_q;

  // ----------------------------------------
  // mtime counter and compare
  // ----------------------------------------
  // a bus load wins over a tick in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q <= '0;
      irq_q   <= 1'b0;
    end else begin
      if (mtime_we_i) begin
        mtime_q <= mtime_wdata_i;
      end else if (tick) begin
        mtime_q <= mtime_q + mtime_t'(1);
      end
      irq_q <= (mtime_q >= mtimecmp_i);
    end
  end

  assign mtime_o     = mtime_q;
  assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

//--- debug_req_gate.sv
// debug request gate
// keeps the debug request low for a fixed window after reset so
// boot code runs before debug can halt the core

`timescale 1ns/100ps
`default_nettype none

module debug_req_gate (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic debug_req_i,
  output logic      debug_req_o
);
  import soc_lite_pkg::*;

  dbg_cnt_t cnt_q;
  logic     blocked;

  // down counter, stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= dbg_cnt_t'(DebugDelayCycles);
    end else if (blocked) begin
      cnt_q <= cnt_q - dbg_cnt_t'(1);
    end
  end

  assign blocked     = (cnt_q != '0);
  assign debug_req_o = blocked ? 1'b0 : debug_req_i;

  a_blocked_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cnt_q != '0) |-> !debug_req_o);

endmodule

`default_nettype wire

//--- mem_bus_if.sv
// decoded request bus between the address decoder and one target
// single cycle strobe, read data valid one cycle after req

`timescale 1ns/100ps
`default_nettype none

interface mem_bus_if;
  import soc_lite_pkg::*;

  logic  req;
  logic  we;
  // offset inside the target window
  addr_t addr;
  data_t wdata;
  data_t rdata;

  modport master (
    output req, we, addr, wdata,
    input  rdata
  );

  modport slave (
    input  req, we, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

//--- soc_addr_decode.sv
// address decoder for the soc lite bus
// routes each request to the rom or the clint and returns
// read data, a valid pulse and an error flag one cycle later

`timescale 1ns/100ps
`default_nettype none

module soc_addr_decode (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                req_i,
  input  wire logic                we_i,
  input  wire soc_lite_pkg::addr_t addr_i,
  input  wire soc_lite_pkg::data_t wdata_i,
  output soc_lite_pkg::data_t      rdata_o,
  output logic                     rvalid_o,
  output logic                     err_o,
  mem_bus_if.master                rom_o,
  mem_bus_if.master                clint_o
);
  import soc_lite_pkg::*;

  target_e tgt;
  target_e sel_q;
  logic    err;
  logic    err_q;
  logic    rvalid_q;

  // ----------------------------------------
  // request side
  // ----------------------------------------
  always_comb begin
    tgt = TGT_NONE;
    if ((addr_i >= RomBase) && (addr_i < RomBase + RomLength)) begin
      tgt = TGT_ROM;
    end else if ((addr_i >= ClintBase) && (addr_i < ClintBase + ClintLength)) begin
      tgt = TGT_CLINT;
    end
  end

  // unmapped address or a write into the rom
  assign err = (tgt == TGT_NONE) || ((tgt == TGT_ROM) && we_i);

  // rom writes never reach the rom
  assign rom_o.req   = req_i && (tgt == TGT_ROM) && !we_i;
  assign rom_o.we    = we_i;
  assign rom_o.addr  = addr_i - RomBase;
  assign rom_o.wdata = wdata_i;

  assign clint_o.req   = req_i && (tgt == TGT_CLINT);
  assign clint_o.we    = we_i;
  assign clint_o.addr  = addr_i - ClintBase;
  assign clint_o.wdata = wdata_i;

  // ----------------------------------------
  // response side
  // ----------------------------------------
  // sel_q names the target whose rdata is returned, none for writes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q    <= TGT_NONE;
      err_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      sel_q    <= (req_i && !we_i && !err) ? tgt : TGT_NONE;
      err_q    <= req_i && err;
      rvalid_q <= req_i;
    end
  end

  always_comb begin
    case (sel_q)
      TGT_ROM:   rdata_o = rom_o.rdata;
      TGT_CLINT: rdata_o = clint_o.rdata;
      default:   rdata_o = '0;
    endcase
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

  a_one_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rom_o.req && clint_o.req));

  a_rvalid_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |=> rvalid_o);

endmodule

`default_nettype wire

//--- soc_lite.f
+incdir+.
soc_lite_pkg.sv
mem_bus_if.sv
soc_addr_decode.sv
boot_rom.sv
clint_regs.sv
clint_timer.sv
debug_req_gate.sv
soc_lite_top.sv
tb_soc_lite.sv

//--- soc_lite_pkg.sv
// soc lite package
// widths, address map, boot rom contents and debug delay
// shared by the decoder, the targets and the testbench model

`default_nettype none

package soc_lite_pkg;

  // ----------------------------------------
  // types
  // ----------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [63:0] mtime_t;

  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_CLINT,
    TGT_NONE
  } target_e;

  // ----------------------------------------
  // address map
  // ----------------------------------------
  localparam addr_t RomBase     = 32'h0000_1000;
  localparam addr_t RomLength   = 32'h0000_0040;
  localparam addr_t ClintBase   = 32'h0200_0000;
  localparam addr_t ClintLength = 32'h0001_0000;

  // clint register offsets inside its window
  localparam addr_t ClintMsipOff       = 32'h0000_0000;
  localparam addr_t ClintMtimecmpLoOff = 32'h0000_4000;
  localparam addr_t ClintMtimecmpHiOff = 32'h0000_4004;
  localparam addr_t ClintMtimeLoOff    = 32'h0000_bff8;
  localparam addr_t ClintMtimeHiOff    = 32'h0000_bffc;

  // ----------------------------------------
  // boot rom
  // ----------------------------------------
  localparam int unsigned RomWords = 16;

  // short boot stub followed by a few constant words
  localparam data_t RomTable [RomWords] = '{
    32'h0000_0297, 32'hf140_2573, 32'h0202_8593, 32'h0202_a303,
    32'h0003_0067, 32'h1050_0073, 32'hffdf_f06f, 32'h0000_0013,
    32'h8000_0000, 32'h0000_0001, 32'h0200_0000, 32'h0000_bff8,
    32'h0000_4000, 32'h0000_0040, 32'h0000_ffff, 32'h5a5a_a5a5
  };

  // ----------------------------------------
  // debug request window after reset
  // ----------------------------------------
  localparam int unsigned DebugDelayCycles = 64;
  localparam int unsigned DebugCntWidth    = $clog2(DebugDelayCycles + 1);

  typedef logic [DebugCntWidth-1:0] dbg_cnt_t;

endpackage

`default_nettype wire

//--- soc_lite_top.sv
// soc lite control island
// simple request bus decoded onto a boot rom and a clint,
// plus the post-reset debug request gate

`timescale 1ns/100ps
`default_nettype none

module soc_lite_top (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                rtc_i,
  input  wire logic                req_i,
  input  wire logic                we_i,
  input  wire soc_lite_pkg::addr_t addr_i,
  input  wire soc_lite_pkg::data_t wdata_i,
  input  wire logic                debug_req_i,
  output soc_lite_pkg::data_t      rdata_o,
  output logic                     rvalid_o,
  output logic                     err_o,
  output logic                     timer_irq_o,
  output logic                     ipi_o,
  output logic                     debug_req_o
);
  import soc_lite_pkg::*;

  mtime_t mtime;
  mtime_t mtimecmp;
  mtime_t mtime_wdata;
  logic   mtime_we;

  mem_bus_if rom_bus ();
  mem_bus_if clint_bus ();

  // ----------------------------------------
  // bus decode and targets
  // ----------------------------------------
  soc_addr_decode i_soc_addr_decode (
    .clk_i    ( clk_i     ),
    .rst_ni   ( rst_ni    ),
    .req_i    ( req_i     ),
    .we_i     ( we_i      ),
    .addr_i   ( addr_i    ),
    .wdata_i  ( wdata_i   ),
    .rdata_o  ( rdata_o   ),
    .rvalid_o ( rvalid_o  ),
    .err_o    ( err_o     ),
    .rom_o    ( rom_bus   ),
    .clint_o  ( clint_bus )
  );

  boot_rom i_boot_rom (
    .clk_i ( clk_i   ),
    .bus_i ( rom_bus )
  );

  clint_regs i_clint_regs (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .mtime_i       ( mtime       ),
    .mtimecmp_o    ( mtimecmp    ),
    .msip_o        ( ipi_o       ),
    .mtime_we_o    ( mtime_we    ),
    .mtime_wdata_o ( mtime_wdata ),
    .bus_i         ( clint_bus   )
  );

  clint_timer i_clint_timer (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .rtc_i         ( rtc_i       ),
    .mtimecmp_i    ( mtimecmp    ),
    .mtime_we_i    ( mtime_we    ),
    .mtime_wdata_i ( mtime_wdata ),
    .mtime_o       ( mtime       ),
    .timer_irq_o   ( timer_irq_o )
  );

  // ----------------------------------------
  // debug
  // ----------------------------------------
  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

//--- tb_soc_lite_model.svh
// reference model for the soc lite testbench
// address map, boot rom words, clint registers and debug window

`ifndef TB_SOC_LITE_MODEL_SVH
`define TB_SOC_LITE_MODEL_SVH

// clint state as seen from the bus
logic   m_msip;
mtime_t m_mtimecmp;
mtime_t m_mtime;

function automatic void model_reset();
  m_msip     = 1'b0;
  m_mtimecmp = '1;
  m_mtime    = '0;
endfunction

// offset below the base wraps to a large value and misses the window
function automatic target_e model_target(addr_t addr);
  if (addr - RomBase < RomLength)
    return TGT_ROM;
  if (addr - ClintBase < ClintLength)
    return TGT_CLINT;
  return TGT_NONE;
endfunction

function automatic logic model_err(addr_t addr, logic we);
  return (model_target(addr) == TGT_NONE) || ((model_target(addr) == TGT_ROM) && we);
endfunction

// writes and errors return zero
function automatic data_t model_rdata(addr_t addr, logic we);
  if (we || model_err(addr, we))
    return '0;
  if (model_target(addr) == TGT_ROM)
    return RomTable[4'((addr - RomBase) >> 2)];
  case (addr - ClintBase)
    ClintMsipOff:       return {31'b0, m_msip};
    ClintMtimecmpLoOff: return m_mtimecmp[31:0];
    ClintMtimecmpHiOff: return m_mtimecmp[63:32];
    ClintMtimeLoOff:    return m_mtime[31:0];
    ClintMtimeHiOff:    return m_mtime[63:32];
    default:            return '0;
  endcase
endfunction

function automatic void model_write(addr_t addr, data_t wdata);
  if (model_target(addr) != TGT_CLINT)
    return;
  case (addr - ClintBase)
    ClintMsipOff:       m_msip = wdata[0];
    ClintMtimecmpLoOff: m_mtimecmp[31:0] = wdata;
    ClintMtimecmpHiOff: m_mtimecmp[63:32] = wdata;
    ClintMtimeLoOff:    m_mtime[31:0] = wdata;
    ClintMtimeHiOff:    m_mtime[63:32] = wdata;
    default: ;
  endcase
endfunction

// request blocked for the first DebugDelayCycles edges after reset
function automatic logic model_debug(int unsigned edges_seen, logic req_in);
  return (edges_seen >= DebugDelayCycles) ? req_in : 1'b0;
endfunction

`endif

//--- tb_soc_lite.sv
// testbench for the soc lite control island
// random bus traffic, rtc pulses and debug requests checked against a model

`timescale 1ns/100ps
`default_nettype none

module tb_soc_lite;
  import soc_lite_pkg::*;

  // the tests take a little under 2000 cycles
  localparam int unsigned TimeoutCycles = 4000;

  logic        clk_i;
  logic        rst_ni;
  logic        rtc_i;
  logic        req_i;
  logic        we_i;
  addr_t       addr_i;
  data_t       wdata_i;
  logic        debug_req_i;
  data_t       rdata_o;
  logic        rvalid_o;
  logic        err_o;
  logic        timer_irq_o;
  logic        ipi_o;
  logic        debug_req_o;

  logic [31:0] lfsr_q = 32'h0d56f675;
  int unsigned cycles = 0;
  int unsigned edges = 0;
  // response due for the request in flight
  logic        pend_req = 1'b0;
  logic        pend_err;
  data_t       pend_rdata;
  data_t       last_rdata;
  data_t       rnd;
  data_t       rd_lo;
  mtime_t      start;
  mtime_t      cmp;
  int unsigned ahead;

  `include "tb_soc_lite_model.svh"

  soc_lite_top i_soc_lite_top (.*);

  // ----------------------------------------
  // random bits and compare tasks
  // ----------------------------------------
  // fibonacci lfsr, taps 32 22 2 1
  function automatic data_t rand_bits(int unsigned n);
    data_t v;
    logic  fb;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s got %b expected %b", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic check_mtime(input mtime_t got, input mtime_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "mtime mismatch");
    end
  endtask

  // ----------------------------------------
  // bus and rtc drivers
  // ----------------------------------------
  // checks the previous response, then drives the next request
  task automatic bus_cycle(input logic req, input logic we, input addr_t addr,
                           input data_t wdata);
    @(posedge clk_i);
    edges++;
    #2;
    check_bit(rvalid_o, pend_req, "rvalid");
    if (pend_req) begin
      check_bit(err_o, pend_err, "err");
      check_data(rdata_o, pend_rdata, "rdata");
    end
    last_rdata = rdata_o;
    check_bit(ipi_o, m_msip, "ipi");
    check_bit(debug_req_o, model_debug(edges, debug_req_i), "debug_req");
    req_i    = req;
    we_i     = we;
    addr_i   = addr;
    wdata_i  = wdata;
    pend_req = req;
    if (req) begin
      pend_err   = model_err(addr, we);
      pend_rdata = model_rdata(addr, we);
      if (we)
        model_write(addr, wdata);
    end
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) bus_cycle(1'b0, 1'b0, '0, '0);
  endtask

  // one rtc edge, settled in mtime and the irq before it returns
  task automatic rtc_pulse();
    rtc_i = 1'b1;
    idle_cycles(3);
    rtc_i = 1'b0;
    idle_cycles(3);
    m_mtime = m_mtime + mtime_t'(1);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("timeout: tests still running after %0d cycles", cycles);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    rst_ni      = 1'b0;
    rtc_i       = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    debug_req_i = 1'b1;
    model_reset();
    repeat (3) @(posedge clk_i);
    #2;
    check_bit(rvalid_o, 1'b0, "rvalid in reset");
    check_bit(err_o, 1'b0, "err in reset");
    check_bit(timer_irq_o, 1'b0, "timer irq in reset");
    check_bit(ipi_o, 1'b0, "ipi in reset");
    check_bit(debug_req_o, 1'b0, "debug_req in reset");
    rst_ni = 1'b1;

    // debug window, then random pass-through
    idle_cycles(DebugDelayCycles + 6);
    for (int i = 0; i < 100; i++) begin
      bus_cycle(1'b0, 1'b0, '0, '0);
      rnd         = rand_bits(1);
      debug_req_i = rnd[0];
    end

    // back-to-back rom reads
    for (int i = 0; i < 300; i++)
      bus_cycle(1'b1, 1'b0, RomBase + (rand_bits(4) << 2), '0);

    // unmapped accesses, window edges and rom writes
    for (int i = 0; i < 250; i++) begin
      rnd = rand_bits(32);
      if (model_target(rnd) != TGT_NONE)
        rnd = rnd ^ 32'h8000_0000;
      bus_cycle(1'b1, rand_bits(1) != 0, rnd, rand_bits(32));
    end
    bus_cycle(1'b1, 1'b0, RomBase - 4, '0);
    bus_cycle(1'b1, 1'b0, RomBase + RomLength, '0);
    bus_cycle(1'b1, 1'b0, ClintBase + ClintLength, '0);
    for (int i = 0; i < 50; i++)
      bus_cycle(1'b1, 1'b1, RomBase + (rand_bits(4) << 2), rand_bits(32));

    // clint register writes and read-back
    for (int i = 0; i < 60; i++) begin
      bus_cycle(1'b1, 1'b1, ClintBase + ClintMsipOff, rand_bits(32));
      bus_cycle(1'b1, 1'b0, ClintBase + ClintMsipOff, '0);
      bus_cycle(1'b1, 1'b1, ClintBase + ClintMtimecmpLoOff, rand_bits(32));
      bus_cycle(1'b1, 1'b1, ClintBase + ClintMtimecmpHiOff, rand_bits(32));
      bus_cycle(1'b1, 1'b0, ClintBase + ClintMtimecmpLoOff, '0);
      bus_cycle(1'b1, 1'b0, ClintBase + ClintMtimecmpHiOff, '0);
      bus_cycle(1'b1, 1'b1, ClintBase + ClintMtimeLoOff, rand_bits(32));
      bus_cycle(1'b1, 1'b1, ClintBase + ClintMtimeHiOff, rand_bits(32));
      bus_cycle(1'b1, 1'b0, ClintBase + ClintMtimeLoOff, '0);
      bus_cycle(1'b1, 1'b0, ClintBase + ClintMtimeHiOff, '0);
      bus_cycle(1'b1, 1'b0, ClintBase + (rand_bits(16) & 32'hfffc), '0);
    end

    // mtime ticks and the timer interrupt, top bit clear so no wrap
    for (int r = 0; r < 3; r++) begin
      start = {rand_bits(32) & 32'h7fff_ffff, rand_bits(32)};
      ahead = 2 + rand_bits(2);
      cmp   = start + mtime_t'(ahead);
      bus_cycle(1'b1, 1'b1, ClintBase + ClintMtimeLoOff, start[31:0]);
      bus_cycle(1'b1, 1'b1, ClintBase + ClintMtimeHiOff, start[63:32]);
      bus_cycle(1'b1, 1'b1, ClintBase + ClintMtimecmpHiOff, cmp[63:32]);
      bus_cycle(1'b1, 1'b1, ClintBase + ClintMtimecmpLoOff, cmp[31:0]);
      idle_cycles(4);
      check_bit(timer_irq_o, 1'b0, "timer irq before ticks");
      for (int unsigned n = 1; n <= 6; n++) begin
        rtc_pulse();
        check_bit(timer_irq_o, n >= ahead, "timer irq after tick");
      end
      bus_cycle(1'b1, 1'b0, ClintBase + ClintMtimeLoOff, '0);
      bus_cycle(1'b1, 1'b0, ClintBase + ClintMtimeHiOff, '0);
      rd_lo = last_rdata;
      idle_cycles(1);
      check_mtime({last_rdata, rd_lo}, start + mtime_t'(6), "mtime after ticks");
    end

    idle_cycles(2);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
